//--- cpu_pkg.sv
//########################################
// cpu shared definitions
//########################################
package cpu_pkg;

  typedef logic signed [15:0] word_t;    // register and memory data
  typedef logic [15:0]        addr_t;    // byte address
  typedef logic [3:0]         reg_idx_t;

  typedef enum logic [2:0] {
    op_arith   = 3'b000, // add / sub by func
    op_mul_slt = 3'b001, // slt / mul by func
    op_load    = 3'b010,
    op_store   = 3'b011,
    op_beq     = 3'b100,
    op_jump    = 3'b101
  } opcode_e;

  // opcode | rs | rt | rd | func
  typedef struct packed {
    logic [2:0] opcode;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic       func;
  } instr_t;

  typedef enum logic [1:0] {alu_add, alu_sub, alu_mul, alu_slt} alu_op_e;

  typedef enum logic [2:0] {
    st_idle, st_fetch, st_decode, st_exec, st_wb, st_mem
  } core_state_e;

  localparam addr_t pc_reset  = 16'h1000;
  localparam addr_t data_base = 16'h1000; // load/store window
  localparam int    num_regs  = 16;

  // 5-bit signed offset, shares bits with rd/func
  function automatic logic signed [4:0] imm_of(instr_t i);
    return i[4:0];
  endfunction

  function automatic logic [12:0] jump_of(instr_t i);
    return i[12:0];
  endfunction

endpackage

//--- mem_bus_if.sv
//########################################
// memory request bus
//########################################
`timescale 1ns/1ps

interface mem_bus_if;
  import cpu_pkg::*;

  logic  req;
  logic  we;
  addr_t addr;
  word_t wdata;
  word_t rdata; // valid with ack
  logic  ack;   // one-cycle pulse

  modport client (output req, we, addr, wdata, input rdata, ack);
  modport arbiter (input req, we, addr, wdata, output rdata, ack);

endinterface

//--- alu.sv
//########################################
// arithmetic unit
//########################################
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::alu_op_e op,
  output cpu_pkg::word_t   result
);
  import cpu_pkg::*;

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_mul: result = a * b; // keeps low 16 bits
      alu_slt: result = (a < b) ? 16'sd1 : 16'sd0; // signed compare
      default: result = '0;
    endcase
  end

endmodule

//--- reg_file.sv
//########################################
// register file
//########################################
`timescale 1ns/1ps

module reg_file (
  input  logic              clk,
  input  logic              rst_n,
  input  cpu_pkg::reg_idx_t rs_idx,
  input  cpu_pkg::reg_idx_t rt_idx,
  input  logic              rd_capture,
  output cpu_pkg::word_t    rs_data,
  output cpu_pkg::word_t    rt_data,
  input  logic              wr_en,
  input  cpu_pkg::reg_idx_t wr_idx,
  input  cpu_pkg::word_t    wr_data
);
  import cpu_pkg::*;

  word_t regs [num_regs];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // operand latch, held until the next decode
  always_ff @(posedge clk) begin
    if (rd_capture) begin
      rs_data <= regs[rs_idx];
      rt_data <= regs[rt_idx];
    end
  end

endmodule

//--- fetch_unit.sv
//########################################
// instruction fetch
//########################################
`timescale 1ns/1ps

module fetch_unit (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  cpu_pkg::addr_t  pc,
  mem_bus_if.client       bus,
  output cpu_pkg::instr_t instr,
  output logic            done
);

  assign bus.we    = 1'b0; // read only
  assign bus.wdata = '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.req <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= bus.req && bus.ack;
      if (start) bus.req <= 1'b1;
      else if (bus.ack) bus.req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) bus.addr <= pc;
    if (bus.req && bus.ack) instr <= bus.rdata; // valid together with done
  end

  // an open request keeps its address
  assert property (@(posedge clk) disable iff (!rst_n)
    bus.req && !bus.ack |=> bus.req && $stable(bus.addr));

endmodule

//--- load_store_unit.sv
//########################################
// load / store access
//########################################
`timescale 1ns/1ps

module load_store_unit (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  input  logic           write,
  input  cpu_pkg::addr_t addr,
  input  cpu_pkg::word_t wdata,
  mem_bus_if.client      bus,
  output cpu_pkg::word_t load_data,
  output logic           done
);

  logic acked;

  assign acked = bus.req && bus.ack;

  // request control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.req <= 1'b0;
      bus.we  <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= acked;
      if (start) begin
        bus.req <= 1'b1;
        bus.we  <= write;
      end else if (bus.ack) begin
        bus.req <= 1'b0;
        bus.we  <= 1'b0;
      end
    end
  end

  // address and store data frozen at start
  always_ff @(posedge clk) begin
    if (start) begin
      bus.addr  <= addr;
      bus.wdata <= wdata;
    end
    if (acked && !bus.we) begin
      load_data <= bus.rdata;
    end
  end

endmodule

//--- mem_arbiter.sv
//########################################
// memory port arbiter
//########################################
`timescale 1ns/1ps

module mem_arbiter (
  input  logic           clk,
  input  logic           rst_n,
  mem_bus_if.arbiter     fetch_bus,
  mem_bus_if.arbiter     lsu_bus,
  output logic           mem_req,
  output logic           mem_we,
  output cpu_pkg::addr_t mem_addr,
  output cpu_pkg::word_t mem_wdata,
  input  cpu_pkg::word_t mem_rdata,
  input  logic           mem_ack
);

  logic locked;    // transaction in flight
  logic grant_lsu;
  logic sel_lsu;

  assign sel_lsu = locked ? grant_lsu : lsu_bus.req; // lsu wins a tie

  //########################################
  // routing
  //########################################
  assign mem_req   = sel_lsu ? lsu_bus.req   : fetch_bus.req;
  assign mem_we    = sel_lsu ? lsu_bus.we    : fetch_bus.we;
  assign mem_addr  = sel_lsu ? lsu_bus.addr  : fetch_bus.addr;
  assign mem_wdata = sel_lsu ? lsu_bus.wdata : fetch_bus.wdata;

  assign lsu_bus.ack     = sel_lsu && mem_ack;
  assign fetch_bus.ack   = !sel_lsu && mem_ack;
  assign lsu_bus.rdata   = sel_lsu ? mem_rdata : '0;
  assign fetch_bus.rdata = sel_lsu ? '0 : mem_rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked    <= 1'b0;
      grant_lsu <= 1'b0;
    end else if (mem_ack) begin
      locked <= 1'b0; // released on the acknowledge
    end else if (mem_req && !locked) begin
      locked    <= 1'b1;
      grant_lsu <= sel_lsu;
    end
  end

  // ack lands only on the client holding the request
  assert property (@(posedge clk) disable iff (!rst_n)
    mem_ack |-> (lsu_bus.ack && lsu_bus.req) || (fetch_bus.ack && fetch_bus.req));

endmodule

//--- core_ctrl.sv
//########################################
// core control FSM
//########################################
`timescale 1ns/1ps

module core_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  cpu_pkg::instr_t   instr,
  input  logic              fetch_done,
  input  logic              mem_done,
  input  cpu_pkg::word_t    rs_data,
  input  cpu_pkg::word_t    rt_data,
  input  cpu_pkg::word_t    alu_result,
  input  cpu_pkg::word_t    load_data,
  output cpu_pkg::addr_t    pc,
  output logic              fetch_start,
  output logic              rd_capture,
  output logic              mem_start,
  output logic              mem_write,
  output cpu_pkg::addr_t    mem_addr,
  output cpu_pkg::alu_op_e  alu_op,
  output cpu_pkg::word_t    alu_b,
  output logic              wr_en,
  output cpu_pkg::reg_idx_t wr_idx,
  output cpu_pkg::word_t    wr_data,
  output logic              io_stall
);
  import cpu_pkg::*;

  core_state_e       state;
  core_state_e       state_next;
  logic signed [4:0] imm;
  word_t             imm_ext;
  addr_t             pc_plus2;
  addr_t             pc_next;
  logic              is_mem;
  logic              entering_fetch;

  assign imm            = imm_of(instr);
  assign imm_ext        = {{11{imm[4]}}, imm};
  assign pc_plus2       = pc + 16'd2;
  assign is_mem         = (instr.opcode == op_load) || (instr.opcode == op_store);
  assign entering_fetch = (state_next == st_fetch) && (state != st_fetch);

  //########################################
  // decode
  //########################################
  always_comb begin
    alu_op = alu_add;
    alu_b  = rt_data;
    case (instr.opcode)
      op_arith: begin
        if (instr.func) alu_op = alu_sub;
      end
      op_mul_slt: begin
        if (instr.func) alu_op = alu_mul;
        else alu_op = alu_slt;
      end
      op_load, op_store: alu_b = imm_ext; // rs + offset
      default: ;
    endcase
  end

  always_comb begin
    pc_next = pc_plus2;
    if (instr.opcode == op_beq && rs_data == rt_data) begin
      pc_next = pc_plus2 + {imm_ext[14:0], 1'b0};
    end else if (instr.opcode == op_jump) begin
      pc_next = {3'b000, jump_of(instr)};
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle:   state_next = st_fetch;
      st_fetch:  if (fetch_done) state_next = st_decode;
      st_decode: state_next = st_exec;
      st_exec: begin
        if (instr.opcode == op_arith || instr.opcode == op_mul_slt) state_next = st_wb;
        else if (is_mem) state_next = st_mem;
        else state_next = st_fetch; // branch, jump, undefined
      end
      st_wb:     state_next = st_fetch;
      st_mem:    if (mem_done) state_next = st_fetch;
      default:   state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= st_idle;
      pc          <= pc_reset;
      fetch_start <= 1'b0;
      io_stall    <= 1'b1;
    end else begin
      state       <= state_next;
      fetch_start <= entering_fetch; // first fetch cycle, pc already updated
      io_stall    <= !(entering_fetch && state != st_idle);
      if (state == st_exec) pc <= pc_next;
    end
  end

  //########################################
  // memory and writeback
  //########################################
  assign rd_capture = (state == st_fetch) && fetch_done;
  assign mem_start  = (state == st_exec) && is_mem;
  assign mem_write  = (instr.opcode == op_store);
  assign mem_addr   = data_base + {alu_result[14:0], 1'b0};

  assign wr_en   = (state == st_wb) || (state == st_mem && mem_done && !mem_write);
  assign wr_idx  = (state == st_wb) ? instr.rd : instr.rt;
  assign wr_data = (state == st_wb) ? alu_result : load_data;

  // instruction word holds still from decode until the next fetch
  assert property (@(posedge clk) disable iff (!rst_n)
    state inside {st_decode, st_exec, st_wb, st_mem} |=> $stable(instr));

endmodule

//--- cpu_top.sv
//########################################
// cpu top level
//########################################
`timescale 1ns/1ps

module cpu_top (
  input  logic           clk,
  input  logic           rst_n,
  output logic           io_stall,
  output logic           mem_req,
  output logic           mem_we,
  output cpu_pkg::addr_t mem_addr,
  output cpu_pkg::word_t mem_wdata,
  input  cpu_pkg::word_t mem_rdata,
  input  logic           mem_ack
);
  import cpu_pkg::*;

  addr_t    pc;
  addr_t    ls_addr;
  instr_t   instr;
  logic     fetch_start, fetch_done, rd_capture;
  logic     mem_start, mem_write, mem_done;
  word_t    rs_data, rt_data, load_data;
  alu_op_e  alu_op;
  word_t    alu_b, alu_result;
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_data;

  mem_bus_if fetch_bus ();
  mem_bus_if lsu_bus ();

  core_ctrl u_core (
    .clk, .rst_n, .instr, .fetch_done, .mem_done,
    .rs_data, .rt_data, .alu_result, .load_data,
    .pc, .fetch_start, .rd_capture, .mem_start, .mem_write,
    .mem_addr(ls_addr), .alu_op, .alu_b,
    .wr_en, .wr_idx, .wr_data, .io_stall
  );

  reg_file u_rf (
    .clk, .rst_n, .rs_idx(instr.rs), .rt_idx(instr.rt), .rd_capture,
    .rs_data, .rt_data, .wr_en, .wr_idx, .wr_data
  );

  alu u_alu (.a(rs_data), .b(alu_b), .op(alu_op), .result(alu_result));

  fetch_unit u_fetch (
    .clk, .rst_n, .start(fetch_start), .pc, .bus(fetch_bus), .instr, .done(fetch_done)
  );

  load_store_unit u_lsu (
    .clk, .rst_n, .start(mem_start), .write(mem_write), .addr(ls_addr),
    .wdata(rt_data), .bus(lsu_bus), .load_data, .done(mem_done)
  );

  mem_arbiter u_arb (
    .clk, .rst_n, .fetch_bus, .lsu_bus,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack
  );

endmodule

//--- tb_cpu.sv
//########################################
// cpu testbench
//########################################
`timescale 1ns/1ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int    clk_period = 40;
  localparam int    num_instr  = 160;
  localparam int    rng_seed   = 57;
  localparam int    timeout_ns = num_instr * 12 * clk_period + 2000;
  localparam int    prog_words = 8 * num_instr + 16; // room for forward skips
  localparam addr_t boot_pc    = 16'h1000;           // first fetch after reset
  localparam addr_t prog_base  = 16'h1100;           // reached by the jump at reset pc

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } access_t;

  logic  clk;
  logic  rst_n;
  logic  io_stall;
  logic  mem_req;
  logic  mem_we;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;
  logic  mem_ack;

  word_t   mem_image [addr_t]; // memory behind the DUT port
  word_t   ref_mem [addr_t];   // reference copy
  word_t   ref_regs [num_regs];
  addr_t   ref_pc;
  access_t req_q [$];
  int      req_seen = 0;
  int      req_used = 0;
  int      stall_pulses = 0;

  cpu_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //########################################
  // checks
  //########################################
  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("error %s: expected 0x%04h, actual 0x%04h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("error %s: expected %0d, actual %0d", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("error %s: expected %0d, actual %0d", name, exp, act);
      stop_with_failure();
    end
  endtask

  //########################################
  // program and reference model
  //########################################
  // unwritten words read back a pattern of their address
  function automatic word_t fill_word(input addr_t a);
    return word_t'(a ^ 16'hc3a5);
  endfunction

  function automatic word_t read_ref(input addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  task automatic put_word(input addr_t a, input word_t w);
    mem_image[a] = w;
    ref_mem[a]   = w;
  endtask

  // r15 is never written, so it stays a zero base for loads and stores
  task automatic build_program();
    int         i;
    int         k;
    int         kind;
    addr_t      pc;
    reg_idx_t   ra;
    reg_idx_t   rb;
    reg_idx_t   rc;
    logic [4:0] imm;
    put_word(boot_pc, {op_jump, 13'(prog_base)});
    for (i = 0; i < 32; i++) begin
      if (i != 16) put_word(addr_t'(16'h0fe0 + 2 * i), word_t'($urandom));
    end
    k = 0;
    while (k < prog_words) begin
      pc   = prog_base + addr_t'(2 * k);
      ra   = 4'($urandom % 15);
      rb   = 4'($urandom);
      rc   = ($urandom % 2) ? rb : 4'($urandom); // equal indices force a taken beq
      imm  = 5'($urandom);
      kind = $urandom % 6;
      case (kind)
        0, 1: begin // arithmetic, then store the result
          put_word(pc, {2'b00, kind[0], rb, rc, ra, 1'($urandom)});
          put_word(pc + 16'd2, {op_store, 4'd15, ra, imm});
          k += 2;
        end
        2: begin // load, then store the loaded register
          put_word(pc, {op_load, 4'd15, ra, imm});
          put_word(pc + 16'd2, {op_store, 4'd15, ra, 5'($urandom)});
          k += 2;
        end
        3: begin
          put_word(pc, {op_beq, rb, rc, 2'b00, imm[2:0]}); // forward only
          k += 1;
        end
        4: begin
          put_word(pc, {op_jump, 13'(pc + 2 + 2 * imm[2:0])});
          k += 1;
        end
        default: begin
          put_word(pc, {op_store, 4'd15, rb, imm});
          k += 1;
        end
      endcase
    end
  endtask

  // one instruction at ref_pc; returns the next fetch address
  function automatic addr_t iss_step(output logic has_mem, output access_t acc);
    logic [15:0]        w;
    reg_idx_t           rs;
    reg_idx_t           rt;
    reg_idx_t           rd;
    word_t              a;
    word_t              b;
    word_t              offs;
    logic signed [31:0] prod;
    addr_t              next_pc;
    w       = read_ref(ref_pc);
    rs      = w[12:9];
    rt      = w[8:5];
    rd      = w[4:1];
    a       = ref_regs[rs];
    b       = ref_regs[rt];
    offs    = {{11{w[4]}}, w[4:0]};
    next_pc = ref_pc + 16'd2;
    has_mem = 1'b0;
    acc     = '0;
    case (w[15:13])
      op_arith: ref_regs[rd] = w[0] ? a - b : a + b;
      op_mul_slt: begin
        prod = a * b;
        if (w[0]) ref_regs[rd] = prod[15:0]; // low half only
        else ref_regs[rd] = (a < b) ? 16'sd1 : 16'sd0;
      end
      op_load, op_store: begin
        has_mem  = 1'b1;
        acc.we   = w[13];
        acc.addr = addr_t'(4096 + 2 * (int'(a) + int'(offs)));
        if (acc.we) begin
          acc.wdata         = b;
          ref_mem[acc.addr] = b;
        end else begin
          ref_regs[rt] = read_ref(acc.addr);
        end
      end
      op_beq: if (a == b) next_pc = addr_t'(int'(ref_pc) + 2 + 2 * int'(offs));
      op_jump: next_pc = {3'b000, w[12:0]};
      default: ;
    endcase
    return next_pc;
  endfunction

  //########################################
  // memory model and monitors
  //########################################
  initial begin : memory_model
    access_t cur;
    int      delay;
    forever begin
      @(negedge clk);
      if (rst_n && mem_req) begin
        cur = {mem_we, mem_addr, mem_wdata};
        req_q.push_back(cur);
        req_seen++;
        delay = 1 + ($urandom % 4);
        repeat (delay) begin
          @(negedge clk);
          check_flag("request held until ack", 1'b1, mem_req);
          check_flag("direction held until ack", cur.we, mem_we);
          check_addr("address held until ack", cur.addr, mem_addr);
          check_word("write data held until ack", cur.wdata, mem_wdata);
        end
        if (cur.we) mem_image[cur.addr] = cur.wdata;
        else mem_rdata = mem_image.exists(cur.addr) ? mem_image[cur.addr] : fill_word(cur.addr);
        mem_ack = 1'b1;
        @(negedge clk);
        mem_ack = 1'b0;
        check_flag("request released after ack", 1'b0, mem_req);
      end
    end
  end

  initial begin : stall_monitor
    logic was_low;
    was_low = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && !io_stall) begin
        if (was_low) begin
          $display("io_stall stayed low for more than one cycle");
          stop_with_failure();
        end
        stall_pulses++;
      end
      if (u_dut.fetch_bus.req && u_dut.lsu_bus.req) begin
        $display("fetch and load/store requests overlap");
        stop_with_failure();
      end
      was_low = rst_n && !io_stall;
    end
  end

  initial begin : watchdog
    #(timeout_ns * 1ns);
    $display("timeout: processor stopped retiring instructions");
    stop_with_failure();
  end

  task automatic next_access(output access_t acc);
    wait (req_seen > req_used);
    acc = req_q.pop_front();
    req_used++;
  endtask

  initial begin : main
    int      i;
    logic    has_mem;
    access_t acc;
    access_t exp;
    addr_t   next_pc;
    void'($urandom(rng_seed));
    rst_n     = 1'b0;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    foreach (ref_regs[r]) ref_regs[r] = '0;
    ref_pc = boot_pc;
    build_program();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    for (i = 0; i < num_instr; i++) begin
      next_access(acc);
      check_flag($sformatf("instr %0d fetch direction", i), 1'b0, acc.we);
      check_addr($sformatf("instr %0d fetch address", i), ref_pc, acc.addr);
      check_count($sformatf("instr %0d io_stall pulses", i), i, stall_pulses);
      next_pc = iss_step(has_mem, exp);
      if (has_mem) begin
        next_access(acc);
        check_flag($sformatf("instr %0d access direction", i), exp.we, acc.we);
        check_addr($sformatf("instr %0d access address", i), exp.addr, acc.addr);
        if (exp.we) check_word($sformatf("instr %0d store data", i), exp.wdata, acc.wdata);
      end
      ref_pc = next_pc;
    end
    next_access(acc); // last instruction has retired
    check_addr("final fetch address", ref_pc, acc.addr);
    if (stall_pulses != num_instr) begin
      $display("error io_stall pulse count: expected %0d, actual %0d", num_instr, stall_pulses);
      stop_with_failure();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

//--- compile.f
cpu_pkg.sv
mem_bus_if.sv
alu.sv
reg_file.sv
fetch_unit.sv
load_store_unit.sv
mem_arbiter.sv
core_ctrl.sv
cpu_top.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu16

sources:
  - cpu_pkg.sv
  - mem_bus_if.sv
  - alu.sv
  - reg_file.sv
  - fetch_unit.sv
  - load_store_unit.sv
  - mem_arbiter.sv
  - core_ctrl.sv
  - cpu_top.sv
  - target: simulation
    files:
      - tb_cpu.sv
